// File: npu_top.f
logic/npu_arch_pkg.sv
logic/npu_isa_pkg.sv
logic/npu_ctrl.sv
logic/inst_mem.sv
logic/operand_fetch.sv
logic/mac_lane.sv
logic/vector_rf.sv
logic/npu_top.sv
bench/npu_assert.sv
bench/npu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the NPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f npu_top.f --top-module npu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/Vnpu_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

// File: bench/npu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module npu_tb;

    localparam int CLK_HALF   = 4;
    localparam int RST_CYCLES = 10;
    localparam int WAIT_LIMIT = 3000;

    typedef npu_arch_pkg::out_beat_t beat_q_t[$];

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   valid_i;
    npu_arch_pkg::in_beat_t in_i;
    logic                   ready_i;
    logic                   ready_o;
    logic                   valid_o;
    npu_arch_pkg::out_beat_t out_o;

    int    seed = 26;
    int    errors = 0;
    int    beat_count = 0;
    int    cycles = 0;
    logic  bp_en = 1'b0;
    string test_name;

    npu_arch_pkg::in_beat_t in_q[$];
    beat_q_t               exp_q;
    beat_q_t               got_q;
    beat_q_t               ref_q;

    // Model state, persists across programs like the DUT
    npu_arch_pkg::elem_t m_sreg [npu_arch_pkg::SREGS];
    npu_arch_pkg::vec_t  m_vreg [npu_arch_pkg::VREGS];
    npu_arch_pkg::vec_t  m_acc;
    npu_arch_pkg::elem_t rand_data [32];

    npu_top i_npu_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .in_i    (in_i),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .out_o   (out_o)
    );

    always #CLK_HALF clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Instruction builders and reference model
    ////////////////////////////////////////////////////////////////////

    function automatic npu_isa_pkg::inst_u mov_inst(input logic [3:0] rd, input logic func,
                                                   input logic [7:0] imm);
        npu_isa_pkg::inst_u w;
        w.mov.opcode = npu_isa_pkg::OP_MOV;
        w.mov.rd     = rd;
        w.mov.func   = func;
        w.mov.imm    = imm;
        return w;
    endfunction

    function automatic npu_isa_pkg::inst_u vmac_inst(input logic [3:0] rd, input logic [3:0] rs1,
                                                    input logic [3:0] rs2, input logic func);
        npu_isa_pkg::inst_u w;
        w.vmac.opcode = npu_isa_pkg::OP_VMAC;
        w.vmac.rd     = rd;
        w.vmac.rs1    = rs1;
        w.vmac.rs2    = rs2;
        w.vmac.func   = func;
        return w;
    endfunction

    function automatic npu_isa_pkg::inst_u vstore_inst(input logic [3:0] r);
        npu_isa_pkg::inst_u w;
        w           = '0;
        w.vmac.opcode = npu_isa_pkg::OP_VSTORE;
        w.vmac.rs2  = r;
        return w;
    endfunction

    function automatic beat_q_t model_program(input npu_isa_pkg::inst_u prog[$]);
        beat_q_t                 res;
        logic [3:0]              stores[$];
        npu_arch_pkg::elem_t     s;
        npu_arch_pkg::vec_t      src;
        npu_arch_pkg::out_beat_t b;
        foreach (prog[i]) begin
            case (prog[i].mov.opcode)
                npu_isa_pkg::OP_MOV: begin
                    m_sreg[prog[i].mov.rd] = prog[i].mov.func ? {prog[i].mov.imm, 8'h00}
                                                              : {8'h00, prog[i].mov.imm};
                end
                npu_isa_pkg::OP_VMAC: begin
                    s   = m_sreg[prog[i].vmac.rs1];
                    src = m_vreg[prog[i].vmac.rs2];
                    for (int l = 0; l < npu_arch_pkg::LANES; l++) begin
                        m_acc[l] = prog[i].vmac.func ? m_acc[l] + s * src[l] : s * src[l];
                    end
                    m_vreg[prog[i].vmac.rd] = m_acc;
                end
                npu_isa_pkg::OP_VSTORE: begin
                    if (stores.size() < npu_arch_pkg::MAX_STORES) begin
                        stores.push_back(prog[i].vmac.rs2);
                    end
                end
                default: ;
            endcase
        end
        // Drain reads registers after the whole program ran
        foreach (stores[k]) begin
            for (int l = 0; l < npu_arch_pkg::LANES; l++) begin
                b.sop  = (k == 0) && (l == 0);
                b.eop  = (k == stores.size() - 1) && (l == npu_arch_pkg::LANES - 1);
                b.data = m_vreg[stores[k]][l];
                res.push_back(b);
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Compare tasks and output checker
    ////////////////////////////////////////////////////////////////////

    task automatic compare_elem(input string name, input npu_arch_pkg::elem_t exp,
                                input npu_arch_pkg::elem_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s: data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_beat(input string name, input npu_arch_pkg::out_beat_t exp,
                                input npu_arch_pkg::out_beat_t act);
        if (exp.sop !== act.sop || exp.eop !== act.eop) begin
            errors++;
            $display("error %s: sop/eop expected %b%b actual %b%b",
                     name, exp.sop, exp.eop, act.sop, act.eop);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && valid_o && ready_i) begin
            got_q.push_back(out_o);
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: output beat arrived when none was expected", test_name);
            end else begin
                compare_beat(test_name, exp_q[0], out_o);
                compare_elem(test_name, exp_q[0].data, out_o.data);
                void'(exp_q.pop_front());
            end
        end
    end

    // Output back-pressure
    always @(posedge clk) begin
        int rnd;
        #1;
        rnd     = $random(seed);
        ready_i = bp_en ? rnd[0] : 1'b1;
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////

    task automatic add_beat(input logic [15:0] addr, input npu_arch_pkg::elem_t data);
        npu_arch_pkg::in_beat_t b;
        b.sop  = 1'b0;
        b.eop  = 1'b0;
        b.addr = addr;
        b.data = data;
        in_q.push_back(b);
    endtask

    task automatic add_vec(input int r, input int l, input npu_arch_pkg::elem_t data);
        add_beat(16'(32'h0200 + r * 8 + l), data);
    endtask

    task automatic send_packet;
        int n;
        @(posedge clk);
        #1;
        for (int i = 0; i < in_q.size(); i++) begin
            in_i      = in_q[i];
            in_i.sop  = (i == 0);
            in_i.eop  = (i == in_q.size() - 1);
            valid_i   = 1'b1;
            beat_count++;
            n = 0;
            @(negedge clk);
            while (!ready_o && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!ready_o) begin
                errors++;
                $display("%s: ready_o stayed low while sending a packet", test_name);
            end
            @(posedge clk);
            #1;
        end
        valid_i = 1'b0;
        in_i    = '0;
    endtask

    task automatic run_packet(input string name);
        npu_isa_pkg::inst_u prog[$];
        int                 n;
        test_name = name;
        foreach (in_q[i]) begin
            if (in_q[i].addr < 16'h0100) begin
                prog.push_back(in_q[i].data);
            end else if (in_q[i].addr >= 16'h0200 && in_q[i].addr < 16'h0280) begin
                m_vreg[in_q[i].addr[6:3]][in_q[i].addr[2:0]] = in_q[i].data;
            end
        end
        exp_q = model_program(prog);
        got_q.delete();
        send_packet();
        in_q.delete();
        n = 0;
        while ((exp_q.size() != 0 || !ready_o) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: output packet missing %0d beats", name, exp_q.size());
        end else if (!ready_o) begin
            errors++;
            $display("%s: ready_o did not return high after the program", name);
        end
        repeat (20) @(negedge clk);
    endtask

    initial begin
        rst_n   = 1'b0;
        valid_i = 1'b0;
        in_i    = '0;
        ready_i = 1'b1;
        m_acc   = '0;
        for (int i = 0; i < npu_arch_pkg::SREGS; i++) m_sreg[i] = '0;
        for (int i = 0; i < npu_arch_pkg::VREGS; i++) m_vreg[i] = '0;
        for (int i = 0; i < 32; i++) rand_data[i] = 16'($random(seed));
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        if (!ready_o || valid_o) begin
            errors++;
            $display("reset: ready_o should be high and valid_o low after reset");
        end

        // Products from MOV built scalars
        for (int l = 0; l < 8; l++) add_vec(1, l, rand_data[l]);
        for (int l = 0; l < 8; l++) add_vec(2, l, rand_data[8 + l]);
        add_beat(16'h0000, mov_inst(4'd1, 1'b0, 8'h35));
        add_beat(16'h0001, mov_inst(4'd2, 1'b1, 8'h02));
        add_beat(16'h0002, mov_inst(4'd3, 1'b0, 8'hc7));
        add_beat(16'h0003, vmac_inst(4'd3, 4'd1, 4'd1, 1'b0));
        add_beat(16'h0004, vmac_inst(4'd4, 4'd2, 4'd2, 1'b0));
        add_beat(16'h0005, vstore_inst(4'd3));
        add_beat(16'h0006, vstore_inst(4'd4));
        run_packet("vmac_products");

        // Dependent accumulation chain
        add_beat(16'h0000, vmac_inst(4'd5, 4'd1, 4'd2, 1'b0));
        add_beat(16'h0001, vmac_inst(4'd6, 4'd3, 4'd5, 1'b1));
        add_beat(16'h0002, vmac_inst(4'd7, 4'd1, 4'd6, 1'b1));
        add_beat(16'h0003, vstore_inst(4'd7));
        add_beat(16'h0004, vstore_inst(4'd6));
        run_packet("vmac_chain");

        // Three stores, the first register rewritten afterwards
        add_beat(16'h0000, vstore_inst(4'd3));
        add_beat(16'h0001, vstore_inst(4'd5));
        add_beat(16'h0002, vstore_inst(4'd7));
        add_beat(16'h0003, vmac_inst(4'd3, 4'd2, 4'd1, 1'b0));
        run_packet("three_stores");

        // Same readback with and without back-pressure
        add_beat(16'h0000, vstore_inst(4'd1));
        add_beat(16'h0001, vstore_inst(4'd3));
        add_beat(16'h0002, vstore_inst(4'd4));
        run_packet("no_backpressure");
        ref_q = got_q;
        bp_en = 1'b1;
        add_beat(16'h0000, vstore_inst(4'd1));
        add_beat(16'h0001, vstore_inst(4'd3));
        add_beat(16'h0002, vstore_inst(4'd4));
        run_packet("backpressure");
        bp_en = 1'b0;
        if (got_q.size() != ref_q.size()) begin
            errors++;
            $display("backpressure: beat count differs from the unstalled run");
        end else begin
            foreach (ref_q[i]) begin
                compare_beat("backpressure_match", ref_q[i], got_q[i]);
                compare_elem("backpressure_match", ref_q[i].data, got_q[i].data);
            end
        end

        // No store, stray addresses ignored
        add_beat(16'h0100, 16'hdead);
        add_beat(16'h1234, 16'hbeef);
        add_beat(16'h0000, mov_inst(4'd4, 1'b0, 8'h11));
        add_beat(16'h0280, 16'hface);
        run_packet("no_store");
        // Registers 0 and 6 are where the stray beats would alias
        add_beat(16'h0000, vmac_inst(4'd8, 4'd4, 4'd1, 1'b0));
        add_beat(16'h0001, vstore_inst(4'd1));
        add_beat(16'h0002, vstore_inst(4'd8));
        add_beat(16'h0003, vstore_inst(4'd0));
        add_beat(16'h0004, vstore_inst(4'd6));
        run_packet("after_stray");

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Limit grows with every beat sent
    initial begin
        while (cycles <= 200 * beat_count + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: simulation ran past its cycle limit");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/npu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module npu_assert (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          ready_o,
    input wire                          valid_o,
    input wire                          ready_i,
    input wire npu_arch_pkg::out_beat_t out_o
);

    // Stalled output beat must hold
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && !ready_i) |=> (valid_o && $stable(out_o)))
        else $error("output beat changed while stalled");

    a_ready_valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ready_o && valid_o))
        else $error("ready_o and valid_o high together");

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !valid_o)
        else $error("valid_o high out of reset");

endmodule

bind npu_top npu_assert i_npu_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .out_o   (out_o)
);

`default_nettype wire

// File: logic/npu_top.sv
`timescale 1ns/1ns
`default_nettype none

module npu_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           valid_i,
    input  wire npu_arch_pkg::in_beat_t   in_i,
    output logic                          ready_o,
    output logic                          valid_o,
    input  wire                           ready_i,
    output npu_arch_pkg::out_beat_t       out_o
);

    logic                             imem_wen;
    logic [npu_arch_pkg::IMEM_AW-1:0] imem_waddr;
    npu_arch_pkg::elem_t              imem_wdata;
    logic                             fetch_en;
    logic [npu_arch_pkg::IMEM_AW-1:0] pc;
    npu_isa_pkg::inst_u               inst;
    npu_arch_pkg::vload_t             vload;
    logic [npu_isa_pkg::REG_W-1:0]    rs2_idx;
    logic                             store_en;
    logic [npu_isa_pkg::REG_W-1:0]    store_reg;
    logic [npu_isa_pkg::REG_W-1:0]    drain_reg;
    logic [npu_arch_pkg::LANE_W-1:0]  drain_lane;
    npu_arch_pkg::elem_t              drain_elem;
    npu_arch_pkg::exec_t              exec;
    npu_arch_pkg::vec_t               op_vec;
    npu_arch_pkg::vec_t               rs2_vec;
    npu_arch_pkg::vec_t               lane_res;

    npu_ctrl i_npu_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .in_i         (in_i),
        .ready_i      (ready_i),
        .store_en_i   (store_en),
        .store_reg_i  (store_reg),
        .drain_elem_i (drain_elem),
        .ready_o      (ready_o),
        .imem_wen_o   (imem_wen),
        .imem_waddr_o (imem_waddr),
        .imem_wdata_o (imem_wdata),
        .fetch_en_o   (fetch_en),
        .pc_o         (pc),
        .vload_o      (vload),
        .drain_reg_o  (drain_reg),
        .drain_lane_o (drain_lane),
        .valid_o      (valid_o),
        .out_o        (out_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Fetch and decode
    //////////////////////////////////////////////////////////////////////

    inst_mem i_inst_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen_i   (imem_wen),
        .waddr_i (imem_waddr),
        .wdata_i (imem_wdata),
        .ren_i   (fetch_en),
        .raddr_i (pc),
        .inst_o  (inst)
    );

    operand_fetch i_operand_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_i       (inst),
        .inst_valid_i (fetch_en),
        .rs2_vec_i    (rs2_vec),
        .rs2_idx_o    (rs2_idx),
        .exec_o       (exec),
        .vec_o        (op_vec),
        .store_en_o   (store_en),
        .store_reg_o  (store_reg)
    );

    //////////////////////////////////////////////////////////////////////
    // MAC lanes and vector registers
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < npu_arch_pkg::LANES; g++) begin : g_lane
        mac_lane i_mac_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .en_i     (exec.valid),
            .acc_i    (exec.acc),
            .scalar_i (exec.scalar),
            .elem_i   (op_vec[g]),
            .result_o (lane_res[g])
        );
    end

    vector_rf i_vector_rf (
        .clk          (clk),
        .rst_n        (rst_n),
        .vload_i      (vload),
        .wen_i        (exec.valid),
        .wreg_i       (exec.rd),
        .wdata_i      (lane_res),
        .rs2_idx_i    (rs2_idx),
        .drain_reg_i  (drain_reg),
        .drain_lane_i (drain_lane),
        .rs2_vec_o    (rs2_vec),
        .drain_elem_o (drain_elem)
    );

endmodule

`default_nettype wire

// File: logic/vector_rf.sv
`timescale 1ns/1ns
`default_nettype none

module vector_rf (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire npu_arch_pkg::vload_t        vload_i,
    input  wire                              wen_i,
    input  wire [npu_arch_pkg::VREG_W-1:0]   wreg_i,
    input  wire npu_arch_pkg::vec_t          wdata_i,
    input  wire [npu_arch_pkg::VREG_W-1:0]   rs2_idx_i,
    input  wire [npu_arch_pkg::VREG_W-1:0]   drain_reg_i,
    input  wire [npu_arch_pkg::LANE_W-1:0]   drain_lane_i,
    output npu_arch_pkg::vec_t               rs2_vec_o,
    output npu_arch_pkg::elem_t              drain_elem_o
);

    npu_arch_pkg::vec_t vregs [npu_arch_pkg::VREGS];

    // Loads and lane writes never overlap in time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < npu_arch_pkg::VREGS; i++) begin
                vregs[i] <= '0;
            end
        end else begin
            if (wen_i) begin
                vregs[wreg_i] <= wdata_i;
            end
            if (vload_i.en) begin
                vregs[vload_i.vreg][vload_i.lane] <= vload_i.data;
            end
        end
    end

    // Write-through so a dependent VMAC sees the result being written
    assign rs2_vec_o = (wen_i && (wreg_i == rs2_idx_i)) ? wdata_i : vregs[rs2_idx_i];

    assign drain_elem_o = vregs[drain_reg_i][drain_lane_i];

endmodule

`default_nettype wire

// File: logic/mac_lane.sv
`timescale 1ns/1ns
`default_nettype none

module mac_lane (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       en_i,
    input  wire                       acc_i,
    input  wire npu_arch_pkg::elem_t  scalar_i,
    input  wire npu_arch_pkg::elem_t  elem_i,
    output npu_arch_pkg::elem_t       result_o
);

    npu_arch_pkg::elem_t acc;
    npu_arch_pkg::elem_t prod;

    // Product wraps at the element width
    assign prod     = scalar_i * elem_i;
    assign result_o = acc_i ? acc + prod : prod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (en_i) begin
            acc <= result_o;
        end
    end

endmodule

`default_nettype wire

// File: logic/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire npu_isa_pkg::inst_u       inst_i,
    input  wire                           inst_valid_i,
    input  wire npu_arch_pkg::vec_t       rs2_vec_i,
    output logic [npu_isa_pkg::REG_W-1:0] rs2_idx_o,
    output npu_arch_pkg::exec_t           exec_o,
    output npu_arch_pkg::vec_t            vec_o,
    output logic                          store_en_o,
    output logic [npu_isa_pkg::REG_W-1:0] store_reg_o
);

    logic                          dec_valid;
    logic [npu_isa_pkg::OP_W-1:0]  opcode;
    logic                          is_mov;
    logic                          is_vmac;
    npu_arch_pkg::elem_t           mov_val;
    npu_arch_pkg::elem_t           sreg [npu_arch_pkg::SREGS];

    // Instruction word lands one cycle after the fetch request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid_i;
        end
    end

    assign opcode  = inst_i.mov.opcode;
    assign is_mov  = dec_valid && (opcode == npu_isa_pkg::OP_MOV);
    assign is_vmac = dec_valid && (opcode == npu_isa_pkg::OP_VMAC);

    assign store_en_o  = dec_valid && (opcode == npu_isa_pkg::OP_VSTORE);
    assign store_reg_o = inst_i.vmac.rs2;
    assign rs2_idx_o   = inst_i.vmac.rs2;

    //////////////////////////////////////////////////////////////////////
    // Scalar registers
    //////////////////////////////////////////////////////////////////////

    assign mov_val = inst_i.mov.func
        ? {inst_i.mov.imm, {npu_isa_pkg::IMM_W{1'b0}}}
        : {{(npu_arch_pkg::DATA_W - npu_isa_pkg::IMM_W){1'b0}}, inst_i.mov.imm};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < npu_arch_pkg::SREGS; i++) begin
                sreg[i] <= '0;
            end
        end else if (is_mov) begin
            sreg[inst_i.mov.rd] <= mov_val;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lane operands
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_o <= '0;
        end else begin
            exec_o.valid <= is_vmac;
            if (is_vmac) begin
                exec_o.acc    <= inst_i.vmac.func;
                exec_o.rd     <= inst_i.vmac.rd;
                exec_o.scalar <= sreg[inst_i.vmac.rs1];
            end
        end
    end

    // rs2 already carries the lane result written this cycle
    always_ff @(posedge clk) begin
        if (is_vmac) begin
            vec_o <= rs2_vec_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/inst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module inst_mem (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              wen_i,
    input  wire [npu_arch_pkg::IMEM_AW-1:0]  waddr_i,
    input  wire [npu_arch_pkg::DATA_W-1:0]   wdata_i,
    input  wire                              ren_i,
    input  wire [npu_arch_pkg::IMEM_AW-1:0]  raddr_i,
    output npu_isa_pkg::inst_u               inst_o
);

    npu_isa_pkg::inst_u mem [npu_arch_pkg::IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wen_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Holds the last fetched word between fetches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_o <= '0;
        end else if (ren_i) begin
            inst_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: logic/npu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module npu_ctrl (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              valid_i,
    input  wire npu_arch_pkg::in_beat_t      in_i,
    input  wire                              ready_i,
    input  wire                              store_en_i,
    input  wire [npu_isa_pkg::REG_W-1:0]     store_reg_i,
    input  wire npu_arch_pkg::elem_t         drain_elem_i,
    output logic                             ready_o,
    output logic                             imem_wen_o,
    output logic [npu_arch_pkg::IMEM_AW-1:0] imem_waddr_o,
    output npu_arch_pkg::elem_t              imem_wdata_o,
    output logic                             fetch_en_o,
    output logic [npu_arch_pkg::IMEM_AW-1:0] pc_o,
    output npu_arch_pkg::vload_t             vload_o,
    output logic [npu_isa_pkg::REG_W-1:0]    drain_reg_o,
    output logic [npu_arch_pkg::LANE_W-1:0]  drain_lane_o,
    output logic                             valid_o,
    output npu_arch_pkg::out_beat_t          out_o
);

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_RUN,
        ST_WAIT,
        ST_DRAIN
    } state_t;

    state_t                           state;
    logic [npu_arch_pkg::IMEM_AW:0]   prog_len;
    logic [npu_arch_pkg::IMEM_AW:0]   len_next;
    logic [npu_arch_pkg::IMEM_AW-1:0] pc;
    logic                             wait_cnt;
    logic [npu_isa_pkg::REG_W-1:0]    store_list [npu_arch_pkg::MAX_STORES];
    logic [npu_arch_pkg::STORE_W:0]   store_cnt;
    logic [npu_arch_pkg::STORE_W-1:0] drain_idx;
    logic [npu_arch_pkg::LANE_W-1:0]  drain_lane;
    logic                             in_xfer, in_inst, in_vec;
    logic                             issue_last, list_full;
    logic                             out_xfer, last_lane, last_reg;

    //////////////////////////////////////////////////////////////////////
    // Loader
    //////////////////////////////////////////////////////////////////////

    assign ready_o = (state == ST_LOAD);
    assign in_xfer = valid_i && ready_o;

    assign in_inst = (in_i.addr >> npu_arch_pkg::IMEM_AW)
                     == (npu_arch_pkg::INST_BASE >> npu_arch_pkg::IMEM_AW);
    assign in_vec  = (in_i.addr >> npu_arch_pkg::VEC_AW)
                     == (npu_arch_pkg::VEC_BASE >> npu_arch_pkg::VEC_AW);

    assign imem_wen_o   = in_xfer && in_inst;
    assign imem_waddr_o = in_i.addr[npu_arch_pkg::IMEM_AW-1:0];
    assign imem_wdata_o = in_i.data;

    always_comb begin
        vload_o.en   = in_xfer && in_vec;
        vload_o.vreg = in_i.addr[npu_arch_pkg::VEC_AW-1:npu_arch_pkg::LANE_W];
        vload_o.lane = in_i.addr[npu_arch_pkg::LANE_W-1:0];
        vload_o.data = in_i.data;
    end

    // sop restarts the count before this beat adds to it
    assign len_next = (in_i.sop ? '0 : prog_len)
                      + {{npu_arch_pkg::IMEM_AW{1'b0}}, in_inst};

    assign issue_last = ({1'b0, pc} == prog_len - 1'b1);
    assign fetch_en_o = (state == ST_RUN);
    assign pc_o       = pc;

    //////////////////////////////////////////////////////////////////////
    // Stored register list
    //////////////////////////////////////////////////////////////////////

    assign list_full = (store_cnt == npu_arch_pkg::MAX_STORES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_cnt <= '0;
        end else if (in_xfer && in_i.sop) begin
            store_cnt <= '0;
        end else if (store_en_i && !list_full) begin
            store_cnt <= store_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_en_i && !list_full) begin
            store_list[store_cnt[npu_arch_pkg::STORE_W-1:0]] <= store_reg_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drain
    //////////////////////////////////////////////////////////////////////

    assign valid_o   = (state == ST_DRAIN);
    assign out_xfer  = valid_o && ready_i;
    assign last_lane = (drain_lane == npu_arch_pkg::LANES - 1);
    assign last_reg  = ({1'b0, drain_idx} == store_cnt - 1'b1);

    assign drain_reg_o  = store_list[drain_idx];
    assign drain_lane_o = drain_lane;

    always_comb begin
        out_o.sop  = (drain_idx == '0) && (drain_lane == '0);
        out_o.eop  = last_reg && last_lane;
        out_o.data = drain_elem_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_LOAD;
            prog_len   <= '0;
            pc         <= '0;
            wait_cnt   <= 1'b0;
            drain_idx  <= '0;
            drain_lane <= '0;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (in_xfer) begin
                        prog_len <= len_next;
                        if (in_i.eop) begin
                            pc       <= '0;
                            wait_cnt <= 1'b0;
                            state    <= (len_next == '0) ? ST_WAIT : ST_RUN;
                        end
                    end
                end
                ST_RUN: begin
                    pc <= pc + 1'b1;
                    if (issue_last) begin
                        wait_cnt <= 1'b0;
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Two cycles for decode and lane writeback
                    wait_cnt <= 1'b1;
                    if (wait_cnt) begin
                        drain_idx  <= '0;
                        drain_lane <= '0;
                        state      <= (store_cnt == '0) ? ST_LOAD : ST_DRAIN;
                    end
                end
                default: begin
                    if (out_xfer) begin
                        if (last_lane) begin
                            drain_lane <= '0;
                            drain_idx  <= drain_idx + 1'b1;
                            if (last_reg) begin
                                state <= ST_LOAD;
                            end
                        end else begin
                            drain_lane <= drain_lane + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/npu_isa_pkg.sv
`default_nettype none

package npu_isa_pkg;

    localparam int OP_W  = 3;
    localparam int REG_W = 4;
    localparam int IMM_W = 8;

    localparam logic [OP_W-1:0] OP_MOV    = 3'b010;
    localparam logic [OP_W-1:0] OP_VSTORE = 3'b101;
    localparam logic [OP_W-1:0] OP_VMAC   = 3'b110;

    // Scalar move, func picks low or high byte
    typedef struct packed {
        logic [OP_W-1:0]  opcode;
        logic [REG_W-1:0] rd;
        logic             func;
        logic [IMM_W-1:0] imm;
    } mov_fmt_t;

    // Register format, also used by VSTORE through rs2
    typedef struct packed {
        logic [OP_W-1:0]  opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic             func;
    } vmac_fmt_t;

    typedef union packed {
        mov_fmt_t  mov;
        vmac_fmt_t vmac;
    } inst_u;

endpackage

`default_nettype wire

// File: logic/npu_arch_pkg.sv
`default_nettype none

package npu_arch_pkg;

    localparam int DATA_W     = 16;
    localparam int ADDR_W     = 16;
    localparam int LANES      = 8;
    localparam int VREGS      = 16;
    localparam int SREGS      = 16;
    localparam int IMEM_DEPTH = 256;
    localparam int MAX_STORES = 8;

    localparam int LANE_W  = $clog2(LANES);
    localparam int VREG_W  = $clog2(VREGS);
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int STORE_W = $clog2(MAX_STORES);

    // Address map, vector window is register then lane
    localparam logic [ADDR_W-1:0] INST_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] VEC_BASE  = 16'h0200;
    localparam int                VEC_AW    = VREG_W + LANE_W;

    typedef logic [DATA_W-1:0] elem_t;
    typedef elem_t [LANES-1:0] vec_t;

    typedef struct packed {
        logic              sop;
        logic              eop;
        logic [ADDR_W-1:0] addr;
        elem_t             data;
    } in_beat_t;

    typedef struct packed {
        logic  sop;
        logic  eop;
        elem_t data;
    } out_beat_t;

    typedef struct packed {
        logic              en;
        logic [VREG_W-1:0] vreg;
        logic [LANE_W-1:0] lane;
        elem_t             data;
    } vload_t;

    // VMAC operands for the lane stage
    typedef struct packed {
        logic              valid;
        logic              acc;
        logic [VREG_W-1:0] rd;
        elem_t             scalar;
    } exec_t;

endpackage

`default_nettype wire
